/* common/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// address geometry: tag | index | word | byte
	localparam int ADDR_W         = 16;
	localparam int DATA_W         = 16;
	localparam int TAG_W          = 5;
	localparam int INDEX_W        = 8;
	localparam int OFFSET_W       = 3;
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_W         = $clog2(WORDS_PER_LINE);
	localparam int SETS           = 256;

	// main memory, word interleaved over one bank per line word
	localparam int MEM_LATENCY = 2;
	localparam int MEM_WORDS   = 32768;
	localparam int BANKS       = WORDS_PER_LINE;
	localparam int BANK_DEPTH  = MEM_WORDS / BANKS;
	localparam int ROW_W       = $clog2(BANK_DEPTH);
	localparam logic [DATA_W-1:0] MEM_INIT_KEY = 16'ha5a5;

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [WORD_W-1:0]  word_sel_t;
	typedef logic [ROW_W-1:0]   row_t;

	// system request, read when wr is low
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  wr;
	} cpu_req_t;

	typedef struct packed {
		data_t rdata;
		logic  hit;
	} cpu_rsp_t;

	// shared command from controller to both ways
	typedef struct packed {
		index_t    index;
		word_sel_t word;
		tag_t      tag;
		data_t     wdata;
		logic      wr;
		logic      cmp;
		logic      valid_in;
	} way_cmd_t;

	typedef struct packed {
		logic  hit;
		logic  valid;
		logic  dirty;
		tag_t  tag;
		data_t rdata;
	} way_stat_t;

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  wr;
		logic  rd;
	} mem_req_t;

	typedef enum logic [3:0] {
		IDLE     = 4'b0000,
		ACC_RD_0 = 4'b0100,
		ACC_RD_1 = 4'b0101,
		ACC_RD_2 = 4'b0110,
		ACC_RD_3 = 4'b0111,
		ACC_WT_0 = 4'b1000,
		ACC_WT_1 = 4'b1001,
		ACC_WT_2 = 4'b1010,
		ACC_WT_3 = 4'b1011,
		ACC_WT_4 = 4'b1100,
		ACC_WT_5 = 4'b1101
	} ctrl_state_e;

	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	// bit 0 ignored, word aligned
	function automatic word_sel_t addr_word(addr_t a);
		return a[1 +: WORD_W];
	endfunction

	function automatic row_t addr_row(addr_t a);
		return a[OFFSET_W +: ROW_W];
	endfunction

	function automatic addr_t line_addr(tag_t t, index_t i, word_sel_t w);
		return {t, i, w, 1'b0};
	endfunction

endpackage

`default_nettype wire

/* rtl/req_latch.sv */
`default_nettype none

module req_latch (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                req_valid,
	input  cache_pkg::cpu_req_t req,
	input  logic                done,
	output logic                busy,
	output logic                pend_valid,
	output cache_pkg::cpu_req_t pend
);

	logic accept;

	// a strobe only counts while idle
	assign accept = req_valid && !busy;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			busy <= 1'b0;
		else if (done)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
	end

	// request held stable until the controller finishes
	always_ff @(posedge clk)
	begin
		if (accept)
			pend <= req;
	end

	// pending exactly while busy
	assign pend_valid = busy;

	// system must wait for busy low before the next strobe
	a_no_strobe_while_busy: assert property (
		@(posedge clk) disable iff (!arst_n)
		busy |-> !req_valid
	) else $error("request strobe while busy is dropped");

	// controller only finishes a request that was latched
	a_done_needs_pending: assert property (
		@(posedge clk) disable iff (!arst_n)
		done |-> busy
	) else $error("done without a pending request");

endmodule

`default_nettype wire

/* cache/cache_way.sv */
`default_nettype none

module cache_way (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 en,
	input  cache_pkg::way_cmd_t  cmd,
	output cache_pkg::way_stat_t stat
);

	cache_pkg::tag_t  tag_mem  [cache_pkg::SETS];
	cache_pkg::data_t data_mem [cache_pkg::SETS][cache_pkg::WORDS_PER_LINE];
	logic [cache_pkg::SETS-1:0] valid_q;
	logic [cache_pkg::SETS-1:0] dirty_q;

	logic line_valid;
	logic tag_match;
	logic fill_we;
	logic hit_we;

	// lookup at the commanded set
	assign line_valid = valid_q[cmd.index];
	assign tag_match  = tag_mem[cmd.index] == cmd.tag;

	// status is raw set state, only hit depends on en and cmp
	assign stat.valid = line_valid;
	assign stat.dirty = dirty_q[cmd.index];
	assign stat.tag   = tag_mem[cmd.index];
	assign stat.rdata = data_mem[cmd.index][cmd.word];
	assign stat.hit   = en && cmd.cmp && line_valid && tag_match;

	// fill writes tag and word regardless of match
	assign fill_we = en && cmd.wr && cmd.valid_in;
	// compare write only lands on a hit
	assign hit_we  = cmd.wr && stat.hit && !cmd.valid_in;

	always_ff @(posedge clk)
	begin
		if (fill_we || hit_we)
			data_mem[cmd.index][cmd.word] <= cmd.wdata;
		if (fill_we)
			tag_mem[cmd.index] <= cmd.tag;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (fill_we)
		begin
			valid_q[cmd.index] <= 1'b1;
			// cmp on the last fill word of a write miss marks the line dirty
			dirty_q[cmd.index] <= cmd.cmp;
		end
		else if (hit_we)
		begin
			dirty_q[cmd.index] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
`default_nettype none

module cache_ctrl (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 pend_valid,
	input  cache_pkg::cpu_req_t  pend,
	input  cache_pkg::way_stat_t way0,
	input  cache_pkg::way_stat_t way1,
	output cache_pkg::way_cmd_t  cmd,
	output logic                 way0_en,
	output logic                 way1_en,
	output cache_pkg::mem_req_t  mem_req,
	input  cache_pkg::data_t     mem_rdata,
	output logic                 done,
	output logic                 rsp_valid,
	output cache_pkg::cpu_rsp_t  rsp
);

	cache_pkg::ctrl_state_e state;
	cache_pkg::ctrl_state_e next_state;

	logic way_sel;
	logic is_wr;
	logic victim_q;

	logic start;
	logic any_hit;
	logic victim_way;
	logic cur_way;
	logic victim_dirty;
	logic in_wt;
	logic mem_phase;
	logic fill_phase;
	logic [3:0] wt_step;

	cache_pkg::way_stat_t vstat;
	cache_pkg::word_sel_t req_word;
	cache_pkg::word_sel_t wb_word;
	cache_pkg::word_sel_t rd_word;
	cache_pkg::word_sel_t fill_word;

	// ignore the request in the cycle its response goes out
	assign start   = pend_valid && !done;
	assign any_hit = way0.hit || way1.hit;

	// invalid way 0, then invalid way 1, then the victim bit
	assign victim_way   = !way0.valid ? 1'b0 : (!way1.valid ? 1'b1 : victim_q);
	assign cur_way      = (state == cache_pkg::IDLE) ? victim_way : way_sel;
	assign vstat        = cur_way ? way1 : way0;
	assign victim_dirty = vstat.valid && vstat.dirty;

	assign req_word = cache_pkg::addr_word(pend.addr);

	// word numbers follow from the state encoding
	assign wb_word    = cache_pkg::word_sel_t'(state - cache_pkg::ACC_RD_0);
	assign wt_step    = state - cache_pkg::ACC_WT_0;
	assign rd_word    = cache_pkg::word_sel_t'(wt_step);
	assign fill_word  = cache_pkg::word_sel_t'(wt_step - cache_pkg::MEM_LATENCY);
	assign in_wt      = state >= cache_pkg::ACC_WT_0;
	// reads issue early, fill trails by the memory latency
	assign mem_phase  = in_wt && wt_step < cache_pkg::WORDS_PER_LINE;
	assign fill_phase = in_wt && wt_step >= cache_pkg::MEM_LATENCY;

	// way command and enables
	always_comb
	begin
		cmd       = '0;
		cmd.index = cache_pkg::addr_index(pend.addr);
		cmd.tag   = cache_pkg::addr_tag(pend.addr);
		cmd.word  = req_word;
		cmd.wdata = pend.wdata;
		// outside idle only the latched victim is touched
		way0_en   = !way_sel;
		way1_en   = way_sel;
		case (state)
			cache_pkg::IDLE:
			begin
				// compare both ways, write lands only on the hitting one
				way0_en = start;
				way1_en = start;
				cmd.cmp = start;
				cmd.wr  = start && pend.wr;
			end
			cache_pkg::ACC_RD_0, cache_pkg::ACC_RD_1,
			cache_pkg::ACC_RD_2, cache_pkg::ACC_RD_3:
			begin
				// read out the dirty line word by word
				cmd.word = wb_word;
			end
			default:
			begin
				if (fill_phase)
				begin
					cmd.word     = fill_word;
					cmd.wr       = 1'b1;
					cmd.valid_in = 1'b1;
					cmd.cmp      = is_wr && state == cache_pkg::ACC_WT_5;
					// merge write data at the requested word
					cmd.wdata    = (is_wr && fill_word == req_word) ? pend.wdata : mem_rdata;
				end
			end
		endcase
	end

	// memory requests and next state
	always_comb
	begin
		mem_req    = '0;
		next_state = state;
		case (state)
			cache_pkg::IDLE:
			begin
				if (start && !any_hit)
					next_state = victim_dirty ? cache_pkg::ACC_RD_0 : cache_pkg::ACC_WT_0;
			end
			cache_pkg::ACC_RD_0, cache_pkg::ACC_RD_1,
			cache_pkg::ACC_RD_2, cache_pkg::ACC_RD_3:
			begin
				// victim address rebuilt from its stored tag
				mem_req.wr    = 1'b1;
				mem_req.addr  = cache_pkg::line_addr(vstat.tag,
					cache_pkg::addr_index(pend.addr), wb_word);
				mem_req.wdata = vstat.rdata;
				if (state == cache_pkg::ACC_RD_3)
					next_state = cache_pkg::ACC_WT_0;
				else
					next_state = cache_pkg::ctrl_state_e'(state + 4'd1);
			end
			cache_pkg::ACC_WT_0, cache_pkg::ACC_WT_1, cache_pkg::ACC_WT_2,
			cache_pkg::ACC_WT_3, cache_pkg::ACC_WT_4, cache_pkg::ACC_WT_5:
			begin
				if (mem_phase)
				begin
					mem_req.rd   = 1'b1;
					mem_req.addr = cache_pkg::line_addr(cache_pkg::addr_tag(pend.addr),
						cache_pkg::addr_index(pend.addr), rd_word);
				end
				if (state == cache_pkg::ACC_WT_5)
					next_state = cache_pkg::IDLE;
				else
					next_state = cache_pkg::ctrl_state_e'(state + 4'd1);
			end
			default:
			begin
				next_state = cache_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= cache_pkg::IDLE;
			way_sel  <= 1'b0;
			is_wr    <= 1'b0;
			victim_q <= 1'b0;
			done     <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// hit in idle or end of fill
			done  <= (state == cache_pkg::IDLE && start && any_hit) ||
				state == cache_pkg::ACC_WT_5;
			if (state == cache_pkg::IDLE && start && !any_hit)
			begin
				way_sel <= victim_way;
				is_wr   <= pend.wr;
			end
			if (state == cache_pkg::ACC_WT_5)
				victim_q <= !victim_q;
		end
	end

	// response payload
	always_ff @(posedge clk)
	begin
		if (state == cache_pkg::IDLE && start)
		begin
			rsp.hit   <= any_hit;
			rsp.rdata <= way1.hit ? way1.rdata : way0.rdata;
		end
		else if (fill_phase && fill_word == req_word)
		begin
			// catch the requested word as it streams in
			rsp.rdata <= mem_rdata;
		end
	end

	assign rsp_valid = done;

	a_state_legal: assert property (
		@(posedge clk) disable iff (!arst_n)
		state inside {cache_pkg::IDLE, cache_pkg::ACC_RD_0, cache_pkg::ACC_RD_1,
			cache_pkg::ACC_RD_2, cache_pkg::ACC_RD_3, cache_pkg::ACC_WT_0,
			cache_pkg::ACC_WT_1, cache_pkg::ACC_WT_2, cache_pkg::ACC_WT_3,
			cache_pkg::ACC_WT_4, cache_pkg::ACC_WT_5}
	) else $error("controller in an illegal state");

	// a line lives in at most one way
	a_single_hit: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(way0.hit && way1.hit)
	) else $error("both ways hit");

endmodule

`default_nettype wire

/* rtl/main_mem.sv */
`default_nettype none

module main_mem (
	input  logic                clk,
	input  cache_pkg::mem_req_t req,
	output cache_pkg::data_t    rdata
);

	cache_pkg::word_sel_t sel;
	cache_pkg::row_t      row;
	cache_pkg::data_t     bank_rd [cache_pkg::BANKS];

	cache_pkg::word_sel_t sel_q;
	logic                 rd_q;
	cache_pkg::data_t     rdata_q;

	// bank by word within the line, row by line address
	assign sel = cache_pkg::addr_word(req.addr);
	assign row = cache_pkg::addr_row(req.addr);

	for (genvar b = 0; b < cache_pkg::BANKS; b++)
	begin : g_bank
		cache_pkg::data_t mem [cache_pkg::BANK_DEPTH];
		cache_pkg::data_t rd_word;

		// word address xor key
		initial
		begin
			for (int r = 0; r < cache_pkg::BANK_DEPTH; r++)
			begin
				mem[r] = cache_pkg::data_t'({cache_pkg::row_t'(r), cache_pkg::word_sel_t'(b)})
					^ cache_pkg::MEM_INIT_KEY;
			end
		end

		always @(posedge clk)
		begin
			if (req.wr && sel == b)
				mem[row] <= req.wdata;
			// stage 1, every bank reads the same row
			if (req.rd)
				rd_word <= mem[row];
		end

		assign bank_rd[b] = rd_word;
	end

	// stage 2, pick the addressed bank
	always_ff @(posedge clk)
	begin
		rd_q  <= req.rd;
		sel_q <= sel;
		if (rd_q)
			rdata_q <= bank_rd[sel_q];
	end

	// valid two cycles after the read strobe, a new read may follow each cycle
	assign rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/mem_system.sv */
`default_nettype none

module mem_system (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                req_valid,
	input  cache_pkg::cpu_req_t req,
	output logic                rsp_valid,
	output cache_pkg::cpu_rsp_t rsp,
	output logic                busy
);

	// request path
	logic                done;
	logic                pend_valid;
	cache_pkg::cpu_req_t pend;

	// cache ways
	cache_pkg::way_cmd_t  cmd;
	logic                 way0_en;
	logic                 way1_en;
	cache_pkg::way_stat_t way0_stat;
	cache_pkg::way_stat_t way1_stat;

	// memory side
	cache_pkg::mem_req_t mem_req;
	cache_pkg::data_t    mem_rdata;

	req_latch req_latch_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.done       (done),
		.busy       (busy),
		.pend_valid (pend_valid),
		.pend       (pend)
	);

	cache_ctrl cache_ctrl_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.pend_valid (pend_valid),
		.pend       (pend),
		.way0       (way0_stat),
		.way1       (way1_stat),
		.cmd        (cmd),
		.way0_en    (way0_en),
		.way1_en    (way1_en),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.done       (done),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp)
	);

	// both ways see the same command, enables pick the target
	cache_way way0_i (
		.clk    (clk),
		.arst_n (arst_n),
		.en     (way0_en),
		.cmd    (cmd),
		.stat   (way0_stat)
	);

	cache_way way1_i (
		.clk    (clk),
		.arst_n (arst_n),
		.en     (way1_en),
		.cmd    (cmd),
		.stat   (way1_stat)
	);

	main_mem main_mem_i (
		.clk   (clk),
		.req   (mem_req),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

/* test/tb_mem_system.sv */
`default_nettype none

module tb_mem_system;

	// up to 14 cycles for each of 700 requests plus margin
	localparam int MAX_REQS       = 700;
	localparam int CYCLES_PER_REQ = 14;
	localparam int TIMEOUT_CYCLES = MAX_REQS * CYCLES_PER_REQ + 2200;
	localparam int RANDOM_REQS    = 600;

	// response delay in edges counted from the strobe edge
	localparam int HIT_CYCLES  = 2;
	localparam int FILL_CYCLES = 6;
	localparam int WB_CYCLES   = 4;

	logic                clk = 1'b0;
	logic                arst_n;
	logic                req_valid;
	cache_pkg::cpu_req_t req;
	logic                rsp_valid;
	cache_pkg::cpu_rsp_t rsp;
	logic                busy;

	integer seed;
	int     cycle_count = 0;
	int     checks = 0;
	int     errors = 0;
	int     test_errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;

	// flat memory image holding the latest value of every word
	cache_pkg::data_t ref_mem [cache_pkg::MEM_WORDS];
	// tag state of both ways
	cache_pkg::tag_t m_tag   [2][cache_pkg::SETS];
	logic            m_valid [2][cache_pkg::SETS];
	logic            m_dirty [2][cache_pkg::SETS];
	logic            m_victim;

	mem_system mem_system_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.busy      (busy)
	);

	always #5 clk = ~clk;

	// watchdog
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: no response after %0d cycles, run stopped", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic reset_model();
		for (int i = 0; i < cache_pkg::MEM_WORDS; i++)
			ref_mem[i] = 16'(i) ^ 16'ha5a5;
		for (int s = 0; s < cache_pkg::SETS; s++)
		begin
			m_valid[0][s] = 1'b0;
			m_valid[1][s] = 1'b0;
			m_dirty[0][s] = 1'b0;
			m_dirty[1][s] = 1'b0;
			m_tag[0][s]   = '0;
			m_tag[1][s]   = '0;
		end
		m_victim = 1'b0;
	endtask

	// predicts the response and then updates the model
	task automatic predict_access(
		input  cache_pkg::addr_t addr,
		input  cache_pkg::data_t wdata,
		input  logic             wr,
		output logic             exp_hit,
		output cache_pkg::data_t exp_rdata,
		output int               exp_cycles
	);
		logic [7:0]  idx;
		logic [4:0]  tg;
		logic [14:0] widx;
		logic        hit0;
		logic        hit1;
		logic        way;
		// tag | index | word | byte
		idx     = addr[10:3];
		tg      = addr[15:11];
		widx    = addr[15:1];
		hit0    = m_valid[0][idx] && m_tag[0][idx] == tg;
		hit1    = m_valid[1][idx] && m_tag[1][idx] == tg;
		exp_hit = hit0 || hit1;
		if (exp_hit)
		begin
			way = hit1;
			exp_cycles = HIT_CYCLES;
			if (wr)
				m_dirty[way][idx] = 1'b1;
		end
		else
		begin
			// invalid way 0 first then invalid way 1 then the victim bit
			if (!m_valid[0][idx])
				way = 1'b0;
			else if (!m_valid[1][idx])
				way = 1'b1;
			else
				way = m_victim;
			exp_cycles = HIT_CYCLES + FILL_CYCLES;
			// dirty victim is written back before the fill
			if (m_valid[way][idx] && m_dirty[way][idx])
				exp_cycles += WB_CYCLES;
			m_tag[way][idx]   = tg;
			m_valid[way][idx] = 1'b1;
			m_dirty[way][idx] = wr;
			// flips after every fill
			m_victim = !m_victim;
		end
		exp_rdata = ref_mem[widx];
		if (wr)
			ref_mem[widx] = wdata;
	endtask

	task automatic report_mismatch(
		input string            name,
		input cache_pkg::data_t got,
		input cache_pkg::data_t exp
	);
		$display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, exp);
		errors++;
		test_errors++;
	endtask

	// issues one request and checks its response
	task automatic issue_request(
		input cache_pkg::addr_t addr,
		input cache_pkg::data_t wdata,
		input logic             wr
	);
		logic             exp_hit;
		cache_pkg::data_t exp_rdata;
		int               exp_cycles;
		int               cycles;
		predict_access(addr, wdata, wr, exp_hit, exp_rdata, exp_cycles);
		@(negedge clk);
		while (busy)
			@(negedge clk);
		@(posedge clk);
		req_valid  <= 1'b1;
		req.addr   <= addr;
		req.wdata  <= wdata;
		req.wr     <= wr;
		@(posedge clk);
		req_valid <= 1'b0;
		cycles = 1;
		// response strobe sampled mid cycle
		@(negedge clk);
		while (!rsp_valid)
		begin
			@(negedge clk);
			cycles++;
		end
		checks++;
		if (cycles != exp_cycles)
			report_mismatch("rsp_valid delay", 16'(cycles), 16'(exp_cycles));
		checks++;
		if (rsp.hit !== exp_hit)
			report_mismatch("rsp.hit", 16'(rsp.hit), 16'(exp_hit));
		// write responses carry no defined data
		if (!wr)
		begin
			checks++;
			if (rsp.rdata !== exp_rdata)
				report_mismatch("rsp.rdata", rsp.rdata, exp_rdata);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic cold_reads();
		cache_pkg::addr_t addr;
		@(negedge clk);
		checks += 2;
		if (rsp_valid !== 1'b0)
			report_mismatch("rsp_valid", 16'(rsp_valid), 16'h0000);
		if (busy !== 1'b0)
			report_mismatch("busy", 16'(busy), 16'h0000);
		// untouched sets so every read misses
		for (int i = 0; i < 4; i++)
		begin
			addr = {cache_pkg::tag_t'(i * 7 + 3), cache_pkg::index_t'(8'h40 + i),
				cache_pkg::word_sel_t'(i), 1'b0};
			issue_request(addr, 16'h0000, 1'b0);
		end
		finish_test("cold_reads");
	endtask

	task automatic write_then_read();
		cache_pkg::addr_t addr;
		addr = {5'd9, 8'h10, 2'd1, 1'b0};
		// allocate then write hit then read hit
		issue_request(addr, 16'hbeef, 1'b1);
		issue_request(addr, 16'hcafe, 1'b1);
		issue_request(addr, 16'h0000, 1'b0);
		finish_test("write_then_read");
	endtask

	task automatic allocate_on_write();
		cache_pkg::addr_t wr_addr;
		cache_pkg::addr_t rd_addr;
		wr_addr = {5'd12, 8'h20, 2'd0, 1'b0};
		rd_addr = {5'd12, 8'h20, 2'd3, 1'b0};
		issue_request(wr_addr, 16'h5a5a, 1'b1);
		// rest of the line came from memory
		issue_request(rd_addr, 16'h0000, 1'b0);
		finish_test("write_allocate");
	endtask

	task automatic dirty_eviction();
		cache_pkg::addr_t a_addr;
		cache_pkg::addr_t b_addr;
		cache_pkg::addr_t c_addr;
		cache_pkg::addr_t spare_addr;
		a_addr     = {5'd1, 8'h80, 2'd2, 1'b0};
		b_addr     = {5'd2, 8'h80, 2'd2, 1'b0};
		c_addr     = {5'd3, 8'h80, 2'd2, 1'b0};
		spare_addr = {5'd4, 8'h81, 2'd0, 1'b0};
		issue_request(a_addr, 16'h1111, 1'b1);
		issue_request(b_addr, 16'h2222, 1'b1);
		// line a sits in way 0 and one extra miss moves the victim bit there
		if (m_victim)
			issue_request(spare_addr, 16'h0000, 1'b0);
		issue_request(c_addr, 16'h3333, 1'b1);
		// both reads miss and need the written back data
		issue_request(a_addr, 16'h0000, 1'b0);
		issue_request(b_addr, 16'h0000, 1'b0);
		finish_test("dirty_eviction");
	endtask

	task automatic random_traffic();
		logic [31:0]      r;
		cache_pkg::addr_t addr;
		for (int i = 0; i < RANDOM_REQS; i++)
		begin
			r = $random(seed);
			// 4 tags over 4 sets for lots of conflicts
			addr = {3'b000, r[1:0], 6'b000000, r[3:2], r[5:4], r[6]};
			issue_request(addr, r[31:16], r[7]);
		end
		finish_test("random_traffic");
	endtask

	initial
	begin
		seed = 32'h895418bb;
		arst_n    <= 1'b0;
		req_valid <= 1'b0;
		req       <= '0;
		reset_model();
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		cold_reads();
		write_then_read();
		allocate_on_write();
		dirty_eviction();
		random_traffic();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
common/cache_pkg.sv
rtl/req_latch.sv
cache/cache_way.sv
cache/cache_ctrl.sv
rtl/main_mem.sv
rtl/mem_system.sv
test/tb_mem_system.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= tb_mem_system
RTL_TOP   ?= mem_system
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
